// File: source/ram_ctrl_params.svh
/*
 * RAM controller sizing constants
 * Data width, address widths and latencies shared by the whole subsystem
 */
`ifndef RAM_CTRL_PARAMS_SVH
`define RAM_CTRL_PARAMS_SVH

// Data word
`define RC_DATA_W     32

// SDRAM word address and the part of it that is installed
`define RC_SDRAM_AW   22
`define RC_STORE_AW   17

// Cycles the SDRAM model stays busy per command
`define RC_SDRAM_LAT  3

// Video RAM, 32768 words
`define RC_VRAM_AW    15
`define RC_VCPU_DLY   4

`endif

// File: source/ram_ctrl_pkg.sv
/*
 * RAM controller types
 * Vector typedefs for data and addresses, and the SDRAM sequencer states
 */
`default_nettype none

`include "ram_ctrl_params.svh"

package ram_ctrl_pkg;

   // Data and address vectors
   typedef logic [`RC_DATA_W-1:0]   word_t;
   typedef logic [`RC_SDRAM_AW-1:0] sdram_addr_t;
   typedef logic [`RC_STORE_AW-1:0] store_addr_t;
   typedef logic [`RC_VRAM_AW-1:0]  vram_addr_t;

   // One-hot SDRAM sequencer states
   typedef enum logic [6:0]
   {
      SD_IDLE     = 7'b000_0001,
      SD_READ     = 7'b000_0010,
      SD_READBSY  = 7'b000_0100,
      SD_READW    = 7'b000_1000,
      SD_WRITE    = 7'b001_0000,
      SD_WRITEBSY = 7'b010_0000,
      SD_WRITEW   = 7'b100_0000
   } sd_state_e;

endpackage

`default_nettype wire

// File: source/ram_ctrl_ifs.sv
/*
 * SDRAM path interfaces
 * host_req_if joins the host port and the sequencer,
 * sdram_bus_if joins the sequencer and the backing store
 */
`timescale 1ns/1ns
`default_nettype none

interface host_req_if;

   // Request side
   ram_ctrl_pkg::sdram_addr_t addr;
   ram_ctrl_pkg::word_t       wdata;
   logic                      req;
   logic                      write;

   // Completion side
   ram_ctrl_pkg::word_t       rdata;
   logic                      rd_complete;
   logic                      wr_complete;

   modport host (output addr, wdata, req, write,
                 input  rdata, rd_complete, wr_complete);

   modport seq  (input  addr, wdata, req, write,
                 output rdata, rd_complete, wr_complete);

endinterface

interface sdram_bus_if;

   // Command from the sequencer
   logic                      cmd_en;
   logic                      cmd_write;
   ram_ctrl_pkg::store_addr_t addr;
   ram_ctrl_pkg::word_t       wdata;

   // Status and data from the store
   logic                      cmd_rdy;
   ram_ctrl_pkg::word_t       rdata;
   logic                      rd_done;
   logic                      wr_done;

   modport master (output cmd_en, cmd_write, addr, wdata,
                   input  cmd_rdy, rdata, rd_done, wr_done);

   modport store  (input  cmd_en, cmd_write, addr, wdata,
                   output cmd_rdy, rdata, rd_done, wr_done);

endinterface

`default_nettype wire

// File: source/sdram_host_port.sv
/*
 * SDRAM host port
 * Puts the host request onto the sequencer interface and returns
 * registered ready and done, qualified by the request still being held
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_host_port
(
   input  wire logic                      clk,
   input  wire logic                      reset,

   input  wire ram_ctrl_pkg::sdram_addr_t addr,
   input  wire ram_ctrl_pkg::word_t       wdata,
   input  wire logic                      req,
   input  wire logic                      write,

   output      ram_ctrl_pkg::word_t       rdata,
   output      logic                      ready,
   output      logic                      done,

   host_req_if.host                       host
);

   //////////////////////////////
   // Request out

   assign host.addr  = addr;
   assign host.wdata = wdata;
   assign host.req   = req;
   assign host.write = write;

   // Read data register lives in the sequencer
   assign rdata = host.rdata;

   //////////////////////////////
   // Acknowledge

   // A dropped request clears its acknowledge on the next edge
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ready <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         ready <= host.rd_complete && req;
         done  <= host.wr_complete && write;
      end
   end

endmodule

`default_nettype wire

// File: source/sdram_sequencer.sv
/*
 * SDRAM sequencer
 * Seven-state one-hot FSM issuing one store command per transaction,
 * with the installed range check and the read data register
 */
`timescale 1ns/1ns
`default_nettype none

`include "ram_ctrl_params.svh"

module sdram_sequencer
(
   input  wire logic   clk,
   input  wire logic   reset,

   host_req_if.seq     host,
   sdram_bus_if.master bus
);

   ram_ctrl_pkg::sd_state_e state;
   ram_ctrl_pkg::sd_state_e state_next;
   ram_ctrl_pkg::word_t     rdata_q;
   logic                    in_range;
   logic                    issue;
   logic                    wr_ack;

   // Only the low address bits are backed by memory
   assign in_range = (host.addr[`RC_SDRAM_AW-1:`RC_STORE_AW] == '0);

   //////////////////////////////
   // State register

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= ram_ctrl_pkg::SD_IDLE;
      else
         state <= state_next;
   end

   // Out of range writes go out as a dummy read, so wait on rd_done
   assign wr_ack = in_range ? bus.wr_done : bus.rd_done;

   always_comb
   begin
      state_next = state;
      unique case (state)
         ram_ctrl_pkg::SD_IDLE:
         begin
            // Read wins when both are raised
            if (host.req)
               state_next = ram_ctrl_pkg::SD_READ;
            else if (host.write)
               state_next = ram_ctrl_pkg::SD_WRITE;
         end
         ram_ctrl_pkg::SD_READ:
            if (bus.cmd_rdy)
               state_next = ram_ctrl_pkg::SD_READBSY;
         ram_ctrl_pkg::SD_READBSY:
            if (bus.rd_done)
               state_next = ram_ctrl_pkg::SD_READW;
         ram_ctrl_pkg::SD_READW:
            if (!host.req)
               state_next = ram_ctrl_pkg::SD_IDLE;
         ram_ctrl_pkg::SD_WRITE:
            if (bus.cmd_rdy)
               state_next = ram_ctrl_pkg::SD_WRITEBSY;
         ram_ctrl_pkg::SD_WRITEBSY:
            if (wr_ack)
               state_next = ram_ctrl_pkg::SD_WRITEW;
         ram_ctrl_pkg::SD_WRITEW:
            if (!host.write)
               state_next = ram_ctrl_pkg::SD_IDLE;
         default:
            state_next = ram_ctrl_pkg::SD_IDLE;
      endcase
   end

   //////////////////////////////
   // Store command

   // Held off while the store is busy
   assign issue = (state == ram_ctrl_pkg::SD_READ || state == ram_ctrl_pkg::SD_WRITE)
                  && bus.cmd_rdy;

   assign bus.cmd_en    = issue;
   assign bus.cmd_write = (state == ram_ctrl_pkg::SD_WRITE) && in_range;
   assign bus.addr      = host.addr[`RC_STORE_AW-1:0];
   assign bus.wdata     = host.wdata;

   //////////////////////////////
   // Read data and completion

   always_ff @(posedge clk)
   begin
      if (reset)
         rdata_q <= '0;
      else if (state == ram_ctrl_pkg::SD_READBSY && bus.rd_done)
         rdata_q <= in_range ? bus.rdata : '1;
   end

   assign host.rdata       = rdata_q;
   assign host.rd_complete = (state == ram_ctrl_pkg::SD_READW);
   assign host.wr_complete = (state == ram_ctrl_pkg::SD_WRITEW);

endmodule

`default_nettype wire

// File: source/sdram_backing_store.sv
/*
 * SDRAM backing store
 * Word array behind a fixed command latency, one command at a time
 */
`timescale 1ns/1ns
`default_nettype none

`include "ram_ctrl_params.svh"

module sdram_backing_store
(
   input  wire logic  clk,
   input  wire logic  reset,

   sdram_bus_if.store bus
);

   localparam int CNT_W = $clog2(`RC_SDRAM_LAT + 1);
   localparam int DEPTH = 1 << `RC_STORE_AW;

   ram_ctrl_pkg::word_t mem [0:DEPTH-1];
   ram_ctrl_pkg::word_t rdata_q;
   logic [CNT_W-1:0]    busy_cnt;
   logic                op_read;
   logic                accept;

   // Installed memory starts out cleared
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = '0;
   end

   assign bus.cmd_rdy = (busy_cnt == '0);
   assign accept      = bus.cmd_en && bus.cmd_rdy;

   //////////////////////////////
   // Busy counter

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_cnt <= '0;
         op_read  <= 1'b0;
      end
      else if (accept)
      begin
         busy_cnt <= CNT_W'(`RC_SDRAM_LAT);
         op_read  <= !bus.cmd_write;
      end
      else if (busy_cnt != '0)
         busy_cnt <= busy_cnt - CNT_W'(1);
   end

   // Done on the last busy cycle
   assign bus.rd_done = (busy_cnt == CNT_W'(1)) && op_read;
   assign bus.wr_done = (busy_cnt == CNT_W'(1)) && !op_read;

   //////////////////////////////
   // Array access at acceptance

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         if (bus.cmd_write)
            mem[bus.addr] <= bus.wdata;
         else
            rdata_q <= mem[bus.addr];
      end
   end

   assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/vram_dual_port.sv
/*
 * Video RAM
 * CPU read/write port and VGA read port with registered reads,
 * plus the ready delay lines for each port
 */
`timescale 1ns/1ns
`default_nettype none

`include "ram_ctrl_params.svh"

module vram_dual_port
(
   input  wire logic                     clk,
   input  wire logic                     reset,

   input  wire ram_ctrl_pkg::vram_addr_t cpu_addr,
   input  wire ram_ctrl_pkg::word_t      cpu_wdata,
   input  wire logic                     cpu_req,
   input  wire logic                     cpu_write,
   output      ram_ctrl_pkg::word_t      cpu_rdata,
   output      logic                     cpu_ready,

   input  wire ram_ctrl_pkg::vram_addr_t vga_addr,
   input  wire logic                     vga_req,
   output      ram_ctrl_pkg::word_t      vga_rdata,
   output      logic                     vga_ready
);

   localparam int DEPTH = 1 << `RC_VRAM_AW;

   ram_ctrl_pkg::word_t     mem [0:DEPTH-1];
   ram_ctrl_pkg::word_t     cpu_rd_q;
   ram_ctrl_pkg::word_t     vga_rd_q;
   ram_ctrl_pkg::word_t     vga_hold;
   logic [`RC_VCPU_DLY-1:0] cpu_req_dly;
   logic                    vga_req_dly;

   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = '0;
   end

   //////////////////////////////
   // CPU port

   always_ff @(posedge clk)
   begin
      if (cpu_write)
         mem[cpu_addr] <= cpu_wdata;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         cpu_rd_q <= '0;
      else if (cpu_req)
         cpu_rd_q <= mem[cpu_addr];
   end

   // Ready comes out of the last stage
   always_ff @(posedge clk)
   begin
      if (reset)
         cpu_req_dly <= '0;
      else
         cpu_req_dly <= {cpu_req_dly[`RC_VCPU_DLY-2:0], cpu_req};
   end

   assign cpu_rdata = cpu_rd_q;
   assign cpu_ready = cpu_req_dly[`RC_VCPU_DLY-1];

   //////////////////////////////
   // VGA port

   always_ff @(posedge clk)
   begin
      if (vga_req)
         vga_rd_q <= mem[vga_addr];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vga_req_dly <= 1'b0;
         vga_hold    <= '0;
      end
      else
      begin
         vga_req_dly <= vga_req;
         if (vga_ready)
            vga_hold <= vga_rd_q;
      end
   end

   // Fresh word while ready, last word read otherwise
   assign vga_ready = vga_req_dly;
   assign vga_rdata = vga_ready ? vga_rd_q : vga_hold;

endmodule

`default_nettype wire

// File: source/ram_controller_top.sv
/*
 * RAM controller top
 * SDRAM request/acknowledge port and dual-port video RAM on one clock
 */
`timescale 1ns/1ns
`default_nettype none

module ram_controller_top
(
   input  wire logic                      clk,
   input  wire logic                      reset,

   input  wire ram_ctrl_pkg::sdram_addr_t sdram_addr,
   input  wire ram_ctrl_pkg::word_t       sdram_data_in,
   input  wire logic                      sdram_req,
   input  wire logic                      sdram_write,
   output      ram_ctrl_pkg::word_t       sdram_data_out,
   output      logic                      sdram_ready,
   output      logic                      sdram_done,

   input  wire ram_ctrl_pkg::vram_addr_t  vram_cpu_addr,
   input  wire ram_ctrl_pkg::word_t       vram_cpu_data_in,
   input  wire logic                      vram_cpu_req,
   input  wire logic                      vram_cpu_write,
   output      ram_ctrl_pkg::word_t       vram_cpu_data_out,
   output      logic                      vram_cpu_ready,

   input  wire ram_ctrl_pkg::vram_addr_t  vram_vga_addr,
   input  wire logic                      vram_vga_req,
   output      ram_ctrl_pkg::word_t       vram_vga_data_out,
   output      logic                      vram_vga_ready
);

   host_req_if  host_if ();
   sdram_bus_if bus_if ();

   //////////////////////////////
   // SDRAM path

   sdram_host_port u_host_port
   (
      .clk   (clk),
      .reset (reset),
      .addr  (sdram_addr),
      .wdata (sdram_data_in),
      .req   (sdram_req),
      .write (sdram_write),
      .rdata (sdram_data_out),
      .ready (sdram_ready),
      .done  (sdram_done),
      .host  (host_if.host)
   );

   sdram_sequencer u_sequencer
   (
      .clk   (clk),
      .reset (reset),
      .host  (host_if.seq),
      .bus   (bus_if.master)
   );

   sdram_backing_store u_store
   (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_if.store)
   );

   //////////////////////////////
   // Video RAM

   vram_dual_port u_vram
   (
      .clk       (clk),
      .reset     (reset),
      .cpu_addr  (vram_cpu_addr),
      .cpu_wdata (vram_cpu_data_in),
      .cpu_req   (vram_cpu_req),
      .cpu_write (vram_cpu_write),
      .cpu_rdata (vram_cpu_data_out),
      .cpu_ready (vram_cpu_ready),
      .vga_addr  (vram_vga_addr),
      .vga_req   (vram_vga_req),
      .vga_rdata (vram_vga_data_out),
      .vga_ready (vram_vga_ready)
   );

endmodule

`default_nettype wire

// File: dv/tb_ref_model.svh
/*
 * Testbench reference model
 * Shadow SDRAM and video RAM with the installed range rule,
 * random number generator and typed compare tasks
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

ram_ctrl_pkg::word_t sd_shadow [ram_ctrl_pkg::store_addr_t];
ram_ctrl_pkg::word_t vram_shadow [ram_ctrl_pkg::vram_addr_t];
logic [31:0]         lcg_state = 32'h6d75;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Upper LCG bits have the longer period
function automatic ram_ctrl_pkg::sdram_addr_t rand_in_range();
   logic [31:0] r;
   r = lcg_next();
   return {{(`RC_SDRAM_AW - `RC_STORE_AW){1'b0}}, r[31 -: `RC_STORE_AW]};
endfunction

function automatic ram_ctrl_pkg::vram_addr_t rand_vram_addr();
   logic [31:0] r;
   r = lcg_next();
   return r[31 -: `RC_VRAM_AW];
endfunction

// Writes above the installed memory are dropped
function automatic void sd_ref_write(input ram_ctrl_pkg::sdram_addr_t addr,
                                     input ram_ctrl_pkg::word_t data);
   if (addr[`RC_SDRAM_AW-1:`RC_STORE_AW] == '0)
      sd_shadow[addr[`RC_STORE_AW-1:0]] = data;
endfunction

// All ones above the installed memory, cleared words never written
function automatic ram_ctrl_pkg::word_t sd_ref_read(input ram_ctrl_pkg::sdram_addr_t addr);
   if (addr[`RC_SDRAM_AW-1:`RC_STORE_AW] != '0)
      return '1;
   if (sd_shadow.exists(addr[`RC_STORE_AW-1:0]))
      return sd_shadow[addr[`RC_STORE_AW-1:0]];
   return '0;
endfunction

function automatic void vram_ref_write(input ram_ctrl_pkg::vram_addr_t addr,
                                       input ram_ctrl_pkg::word_t data);
   vram_shadow[addr] = data;
endfunction

function automatic ram_ctrl_pkg::word_t vram_ref_read(input ram_ctrl_pkg::vram_addr_t addr);
   if (vram_shadow.exists(addr))
      return vram_shadow[addr];
   return '0;
endfunction

task automatic check_word(input string name, input ram_ctrl_pkg::word_t got,
                          input ram_ctrl_pkg::word_t exp);
   if (got !== exp)
   begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      end_with_failure();
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp)
   begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      end_with_failure();
   end
endtask

`endif

// File: dv/ram_controller_tb.sv
/*
 * RAM controller testbench
 * Drives the SDRAM and video RAM ports and checks data and handshake
 * timing against shadow memories
 */
`timescale 1ns/1ns
`default_nettype none

`include "ram_ctrl_params.svh"

module ram_controller_tb;

   localparam int CLK_HALF    = 10;
   localparam int N_SD        = 64;
   localparam int N_OOR_RD    = 8;
   localparam int N_OOR_WR    = 4;
   localparam int N_V         = 32;
   localparam int N_PAIR      = 4;
   localparam int N_OPS       = 2 * N_SD + N_OOR_RD + 2 * N_OOR_WR + 3 * N_V + 4 * N_PAIR;
   localparam int WATCHDOG    = N_OPS * 40 + 200;
   localparam int SD_ACK_WAIT = 40;
   localparam int VRAM_WAIT   = 16;
   // Ready follows the Nth edge, counting the one that samples the request
   localparam int CPU_LAT     = `RC_VCPU_DLY;
   localparam int VGA_LAT     = 1;

   logic                      clk;
   logic                      reset;
   ram_ctrl_pkg::sdram_addr_t sdram_addr;
   ram_ctrl_pkg::word_t       sdram_data_in;
   logic                      sdram_req;
   logic                      sdram_write;
   ram_ctrl_pkg::word_t       sdram_data_out;
   logic                      sdram_ready;
   logic                      sdram_done;
   ram_ctrl_pkg::vram_addr_t  vram_cpu_addr;
   ram_ctrl_pkg::word_t       vram_cpu_data_in;
   logic                      vram_cpu_req;
   logic                      vram_cpu_write;
   ram_ctrl_pkg::word_t       vram_cpu_data_out;
   logic                      vram_cpu_ready;
   ram_ctrl_pkg::vram_addr_t  vram_vga_addr;
   logic                      vram_vga_req;
   ram_ctrl_pkg::word_t       vram_vga_data_out;
   logic                      vram_vga_ready;

   // Inputs as seen by the last rising edge
   int unsigned               edge_cnt;
   logic                      reset_seen;
   logic                      sd_req_seen;
   logic                      sd_write_seen;
   int unsigned               cpu_req_edges [$];
   int unsigned               vga_req_edges [$];

   // Expected responses in arrival order
   ram_ctrl_pkg::word_t       sd_rd_exp_q [$];
   ram_ctrl_pkg::sdram_addr_t sd_wr_q [$];
   ram_ctrl_pkg::word_t       cpu_exp_q [$];
   ram_ctrl_pkg::word_t       vga_exp_q [$];

   ram_ctrl_pkg::sdram_addr_t sd_addrs [N_SD];
   ram_ctrl_pkg::vram_addr_t  v_addrs [N_V];

   task automatic end_with_failure();
      $display("sim failed");
      $fatal(1, "stopping at the first error");
   endtask

`include "tb_ref_model.svh"

   ram_controller_top u_dut
   (
      .clk               (clk),
      .reset             (reset),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   //////////////////////////////
   // Stimulus tasks start and end on a falling edge

   task automatic sdram_start(input logic is_write, input ram_ctrl_pkg::sdram_addr_t addr,
                              input ram_ctrl_pkg::word_t data);
      if (is_write)
      begin
         sd_ref_write(addr, data);
         sd_wr_q.push_back(addr);
      end
      else
         sd_rd_exp_q.push_back(sd_ref_read(addr));
      sdram_addr    = addr;
      sdram_data_in = data;
      sdram_req     = !is_write;
      sdram_write   = is_write;
   endtask

   // Hold the request until acknowledged, then drop it
   task automatic sdram_finish();
      int waited;
      waited = 0;
      while (!(sdram_ready || sdram_done) && waited < SD_ACK_WAIT)
      begin
         @(negedge clk);
         waited = waited + 1;
      end
      if (!(sdram_ready || sdram_done))
      begin
         $display("no acknowledge for the SDRAM request at address %h", sdram_addr);
         end_with_failure();
      end
      sdram_req   = 1'b0;
      sdram_write = 1'b0;
      @(negedge clk);
   endtask

   task automatic sdram_transfer(input logic is_write, input ram_ctrl_pkg::sdram_addr_t addr,
                                 input ram_ctrl_pkg::word_t data);
      sdram_start(is_write, addr, data);
      sdram_finish();
   endtask

   task automatic wait_vram_responses();
      int waited;
      waited = 0;
      while ((cpu_exp_q.size() != 0 || vga_exp_q.size() != 0) && waited < VRAM_WAIT)
      begin
         @(negedge clk);
         waited = waited + 1;
      end
      if (cpu_exp_q.size() != 0 || vga_exp_q.size() != 0)
      begin
         $display("video RAM read got no ready");
         end_with_failure();
      end
   endtask

   task automatic vram_cpu_store(input ram_ctrl_pkg::vram_addr_t addr,
                                 input ram_ctrl_pkg::word_t data);
      vram_ref_write(addr, data);
      vram_cpu_addr    = addr;
      vram_cpu_data_in = data;
      vram_cpu_write   = 1'b1;
      @(negedge clk);
      vram_cpu_write   = 1'b0;
   endtask

   task automatic vram_cpu_fetch(input ram_ctrl_pkg::vram_addr_t addr);
      cpu_exp_q.push_back(vram_ref_read(addr));
      vram_cpu_addr = addr;
      vram_cpu_req  = 1'b1;
      @(negedge clk);
      vram_cpu_req  = 1'b0;
   endtask

   task automatic vga_fetch(input ram_ctrl_pkg::vram_addr_t addr);
      vga_exp_q.push_back(vram_ref_read(addr));
      vram_vga_addr = addr;
      vram_vga_req  = 1'b1;
      @(negedge clk);
      vram_vga_req  = 1'b0;
   endtask

   //////////////////////////////
   // Stimulus

   initial
   begin : stimulus
      ram_ctrl_pkg::sdram_addr_t a;
      ram_ctrl_pkg::word_t       d;
      logic [31:0]               r;
      logic [`RC_SDRAM_AW-`RC_STORE_AW-1:0] top;

      reset            = 1'b1;
      sdram_addr       = '0;
      sdram_data_in    = '0;
      sdram_req        = 1'b0;
      sdram_write      = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req     = 1'b0;
      vram_cpu_write   = 1'b0;
      vram_vga_addr    = '0;
      vram_vga_req     = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      // Idle with no acknowledge allowed
      repeat (8) @(negedge clk);

      // SDRAM writes, then read back
      for (int i = 0; i < N_SD; i++)
      begin
         sd_addrs[i] = rand_in_range();
         sdram_transfer(1'b1, sd_addrs[i], lcg_next());
      end
      for (int i = 0; i < N_SD; i++)
         sdram_transfer(1'b0, sd_addrs[i], '0);

      // Above the installed memory
      for (int i = 0; i < N_OOR_RD + N_OOR_WR; i++)
      begin
         r   = lcg_next();
         top = r[`RC_SDRAM_AW-`RC_STORE_AW-1:0];
         if (top == '0)
            top = 1;
         if (i < N_OOR_RD)
            sdram_transfer(1'b0, {top, r[31 -: `RC_STORE_AW]}, '0);
         else
         begin
            a = sd_addrs[i - N_OOR_RD];
            sdram_transfer(1'b1, {top, a[`RC_STORE_AW-1:0]}, lcg_next());
            sdram_transfer(1'b0, a, '0);
         end
      end

      // Video RAM through the CPU port
      for (int i = 0; i < N_V; i++)
      begin
         v_addrs[i] = rand_vram_addr();
         vram_cpu_store(v_addrs[i], lcg_next());
      end
      for (int i = 0; i < N_V; i++)
      begin
         vram_cpu_fetch(v_addrs[i]);
         wait_vram_responses();
      end

      // VGA port with the output held between reads
      for (int i = 0; i < N_V; i++)
      begin
         vga_fetch(v_addrs[N_V - 1 - i]);
         wait_vram_responses();
         repeat (2) @(negedge clk);
      end

      // CPU video traffic next to SDRAM transactions
      for (int i = 0; i < N_PAIR; i++)
      begin
         a = rand_in_range();
         d = lcg_next();
         sdram_start(1'b1, a, d);
         vram_cpu_store(v_addrs[i], ~d);
         sdram_finish();
         sdram_start(1'b0, a, '0);
         vram_cpu_fetch(v_addrs[i]);
         sdram_finish();
         wait_vram_responses();
      end

      repeat (4) @(negedge clk);
      if (sd_rd_exp_q.size() == 0 && sd_wr_q.size() == 0 &&
          cpu_exp_q.size() == 0 && vga_exp_q.size() == 0)
      begin
         $display("sim passed");
         $finish;
      end
      else
      begin
         $display("responses still outstanding at the end of the run");
         end_with_failure();
      end
   end

   //////////////////////////////
   // Edge monitor and checker

   initial
   begin : edge_monitor
      edge_cnt      = 0;
      reset_seen    = 1'b1;
      sd_req_seen   = 1'b0;
      sd_write_seen = 1'b0;
      forever
      begin
         @(posedge clk);
         edge_cnt      = edge_cnt + 1;
         reset_seen    = reset;
         sd_req_seen   = sdram_req;
         sd_write_seen = sdram_write;
         if (!reset && vram_cpu_req)
            cpu_req_edges.push_back(edge_cnt);
         if (!reset && vram_vga_req)
            vga_req_edges.push_back(edge_cnt);
      end
   end

   initial
   begin : compare
      logic                      ready_was;
      logic                      done_was;
      logic                      fresh;
      logic                      cpu_due;
      logic                      vga_due;
      ram_ctrl_pkg::word_t       last_vga;

      ready_was = 1'b0;
      done_was  = 1'b0;
      fresh     = 1'b1;
      last_vga  = '0;
      forever
      begin
         @(negedge clk);
         if (reset_seen)
         begin
            fresh    = 1'b1;
            last_vga = '0;
         end
         else
         begin
            if (fresh)
            begin
               check_word("sdram_data_out", sdram_data_out, '0);
               check_word("vram_cpu_data_out", vram_cpu_data_out, '0);
               fresh = 1'b0;
            end

            // Acknowledge only while the request is still held
            if (!sd_req_seen)
               check_flag("sdram_ready", sdram_ready, 1'b0);
            if (!sd_write_seen)
               check_flag("sdram_done", sdram_done, 1'b0);
            if (sdram_ready && !ready_was)
            begin
               if (sd_rd_exp_q.size() == 0)
               begin
                  $display("sdram_ready rose with no read outstanding");
                  end_with_failure();
               end
               else
                  check_word("sdram_data_out", sdram_data_out, sd_rd_exp_q.pop_front());
            end
            if (sdram_done && !done_was)
            begin
               if (sd_wr_q.size() == 0)
               begin
                  $display("sdram_done rose with no write outstanding");
                  end_with_failure();
               end
               else
                  void'(sd_wr_q.pop_front());
            end
            ready_was = sdram_ready;
            done_was  = sdram_done;

            // Video ready exactly at the fixed latency
            cpu_due = (cpu_req_edges.size() != 0) &&
                      (cpu_req_edges[0] + CPU_LAT - 1 == edge_cnt);
            check_flag("vram_cpu_ready", vram_cpu_ready, cpu_due);
            if (cpu_due)
            begin
               void'(cpu_req_edges.pop_front());
               check_word("vram_cpu_data_out", vram_cpu_data_out, cpu_exp_q.pop_front());
            end

            vga_due = (vga_req_edges.size() != 0) &&
                      (vga_req_edges[0] + VGA_LAT - 1 == edge_cnt);
            check_flag("vram_vga_ready", vram_vga_ready, vga_due);
            if (vga_due)
            begin
               void'(vga_req_edges.pop_front());
               last_vga = vga_exp_q.pop_front();
            end
            check_word("vram_vga_data_out", vram_vga_data_out, last_vga);
         end
      end
   end

   initial
   begin : watchdog
      repeat (WATCHDOG) @(posedge clk);
      $display("watchdog expired after %0d cycles", WATCHDOG);
      end_with_failure();
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
+incdir+dv
source/ram_ctrl_pkg.sv
source/ram_ctrl_ifs.sv
source/sdram_host_port.sv
source/sdram_sequencer.sv
source/sdram_backing_store.sv
source/vram_dual_port.sv
source/ram_controller_top.sv
dv/ram_controller_tb.sv

// File: Makefile
# Verilator build and run of the RAM controller testbench

BIN  := obj_dir/Vram_controller_tb
SRCS := $(shell grep -v '^+' verilog.f) $(wildcard source/*.svh dv/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): verilog.f $(SRCS)
	verilator --binary --top-module ram_controller_tb -f verilog.f -o Vram_controller_tb

# A $fatal in the testbench gives a failing exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
